// ==== bench/rv_mem_checker.sv ====
`default_nettype none

`include "rv_mem_defs.svh"

module rv_mem_checker
    import rv_bus_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst,
    input  wire apb_req_t   apb_req,
    input  wire apb_rsp_t   apb_rsp,
    input  wire fetch_req_t fetch_req,
    input  wire fetch_rsp_t fetch_rsp,
    output int              error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = `MEM_SIZE_BYTES / 4;

    logic [31:0] image [WORDS] = '{default: 32'h0};  // Reference memory, starts cleared
    int          errors = 0;
    logic        fetch_pending;    // Fetch sampled at the last edge
    logic        fetch_exp_fault;
    logic [31:0] fetch_exp_word;
    int          access_cycles;    // Access cycles seen without pready

    assign error_count = errors;

    // Expected word at a bus address, zero with err outside RAM or misaligned
    function automatic logic [31:0] ref_read(input logic [31:0] addr, output logic err);
        logic [31:0] off;
        off = addr - `MEM_START_ADDRESS;
        err = (addr < `MEM_START_ADDRESS)
              || (addr >= `MEM_START_ADDRESS + 32'(`MEM_SIZE_BYTES))
              || (addr[1:0] != 2'b00);
        if (err) begin
            return 32'h0;
        end
        return image[off[`MEM_INDEX_BITS+1:2]];
    endfunction

    task automatic mismatch(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        errors++;
        $display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
    endtask

    always @(posedge clock) begin : compare
        logic        access;
        logic        exp_err;
        logic        exp_ready;
        logic [31:0] exp_data;
        logic [31:0] off;
        if (rst) begin
            fetch_pending = 1'b0;
            access_cycles = 0;
        end else begin
            // Answer to the fetch of the previous edge
            if (fetch_rsp.valid !== fetch_pending) begin
                mismatch("fetch valid", {31'h0, fetch_rsp.valid}, {31'h0, fetch_pending});
            end else if (fetch_pending) begin
                if (fetch_rsp.fault !== fetch_exp_fault) begin
                    mismatch("fetch fault", {31'h0, fetch_rsp.fault}, {31'h0, fetch_exp_fault});
                end
                if (fetch_rsp.instr.word !== fetch_exp_word) begin
                    mismatch("fetch instr", fetch_rsp.instr.word, fetch_exp_word);
                end
            end
            // New fetch sees the image before this edge's write
            fetch_pending = fetch_req.valid;
            if (fetch_req.valid) begin
                fetch_exp_word = ref_read(fetch_req.addr, fetch_exp_fault);
            end

            access = apb_req.psel && apb_req.penable;
            if (!access) begin
                if (apb_rsp.pready !== 1'b0 || apb_rsp.pslverr !== 1'b0) begin
                    mismatch("idle pready/pslverr", {30'h0, apb_rsp.pready, apb_rsp.pslverr},
                             32'h0);
                end
                access_cycles = 0;
            end else begin
                exp_data  = ref_read(apb_req.paddr, exp_err);
                exp_ready = exp_err || apb_req.pwrite || (access_cycles == 1);  // Read waits once
                if (apb_rsp.pready !== exp_ready) begin
                    mismatch("pready", {31'h0, apb_rsp.pready}, {31'h0, exp_ready});
                end else if (exp_ready) begin
                    if (apb_rsp.pslverr !== exp_err) begin
                        mismatch("pslverr", {31'h0, apb_rsp.pslverr}, {31'h0, exp_err});
                    end
                    if (exp_err || !apb_req.pwrite) begin
                        compare_prdata(apb_rsp.prdata, exp_data);
                    end
                    if (apb_req.pwrite && !exp_err) begin
                        off = apb_req.paddr - `MEM_START_ADDRESS;
                        for (int b = 0; b < 4; b++) begin
                            if (apb_req.pstrb[b]) begin
                                exp_data[8*b +: 8] = apb_req.pwdata[8*b +: 8];  // Strobed lane
                            end
                        end
                        image[off[`MEM_INDEX_BITS+1:2]] = exp_data;
                    end
                    access_cycles = 0;
                end else begin
                    access_cycles++;
                end
            end
        end
    end

    task automatic compare_prdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch("prdata", got, exp);
        end
    endtask

endmodule

`default_nettype wire

// ==== bench/rv_mem_props.sv ====
`default_nettype none

module rv_mem_props
    import rv_bus_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire apb_req_t apb_req,
    input  wire apb_rsp_t apb_rsp,
    input  wire logic     rd_en     // First access cycle of a legal read
);
    timeunit 1ns;
    timeprecision 1ps;

    logic access;  // Access phase of a transfer

    assign access = apb_req.psel && apb_req.penable;

    a_ready_in_access: assert property (@(posedge clock) disable iff (rst)
        apb_rsp.pready |-> access)
        else $error("pready high outside an access phase");

    a_err_with_ready: assert property (@(posedge clock) disable iff (rst)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else $error("pslverr high without pready");

    // Read data follows one wait state
    a_read_wait: assert property (@(posedge clock) disable iff (rst)
        rd_en |=> apb_rsp.pready)
        else $error("pready missing in the cycle after a read was issued");

endmodule

bind apb_mem_bridge rv_mem_props u_props (
    .clock   (clock),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .rd_en   (rd_en)
);

`default_nettype wire

// ==== bench/rv_mem_tb.sv ====
`default_nettype none

`include "rv_mem_defs.svh"

module rv_mem_tb
    import rv_bus_pkg::*;
    import rv_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BASE = `MEM_START_ADDRESS;
    localparam logic [31:0] TOP  = `MEM_START_ADDRESS + 32'(`MEM_SIZE_BYTES);  // Past last byte
    localparam int ACCESS_TIMEOUT = 16;  // Cycles allowed for pready

    logic        clock = 1'b0;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    int          check_errors;
    int          timeout_count = 0;
    logic [31:0] lcg_state = 32'd62;  // Seed

    always #20 clock = ~clock;  // 40 ns period

    rv_mem_top u_dut (
        .clock     (clock),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp)
    );

    rv_mem_checker u_checker (
        .clock       (clock),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .error_count (check_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper halves only, low LCG bits repeat fast
    task automatic next_rand(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r[31:16] = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        r[15:0] = lcg_state[31:16];
    endtask

    // Mostly low window words, some just outside or misaligned
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [31:0] word_off;
        word_off = {24'h0, r[7:2], 2'b00};  // First 64 words
        case (r[30:28])
            3'd0:    return BASE - 32'd16 + {28'h0, r[3:2], 2'b00};  // Below base
            3'd1:    return TOP + {28'h0, r[3:2], 2'b00};            // At or past end
            3'd2:    return BASE + word_off + {30'h0, r[1:0] | 2'b01};
            3'd3:    return TOP - 32'd256 + word_off;                // Last 64 words
            default: return BASE + word_off;
        endcase
    endfunction

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb);
        int waited;
        @(posedge clock);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr,
                     pwdata: data, pstrb: strb};  // Setup phase
        @(posedge clock);
        apb_req.penable <= 1'b1;
        waited = 0;
        @(posedge clock);
        while (!apb_rsp.pready && waited < ACCESS_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (!apb_rsp.pready) begin
            timeout_count++;
            $display("Timeout: APB %s at %h got no pready within %0d cycles",
                     write ? "write" : "read", addr, ACCESS_TIMEOUT);
        end
        apb_req <= '0;  // Back to idle
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        apb_transfer(1'b1, addr, data, strb);
    endtask

    task automatic apb_read(input logic [31:0] addr);
        apb_transfer(1'b0, addr, 32'h0, 4'h0);
    endtask

    // One fetch per cycle over consecutive words
    task automatic fetch_run(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            fetch_req <= '{valid: 1'b1, addr: first + 32'(4 * i)};
        end
        @(posedge clock);
        fetch_req <= '0;
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] pick;
        rst = 1'b1;
        apb_req = '0;
        fetch_req = '0;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        repeat (3) @(posedge clock);  // Quiet cycles after reset

        for (int i = 0; i < 8; i++) begin  // Full words
            next_rand(data);
            addr = BASE + 32'(4 * i);
            apb_write(addr, data, 4'hf);
            apb_read(addr);
        end

        for (int i = 0; i < 16; i++) begin  // Random strobes
            next_rand(pick);
            next_rand(data);
            addr = BASE + {24'h0, pick[7:2], 2'b00};
            apb_write(addr, data, pick[11:8]);
            apb_read(addr);
        end

        fork  // Fetch alongside data writes
            fetch_run(BASE, 64);
            begin
                for (int i = 0; i < 6; i++) begin
                    next_rand(data);
                    apb_write(BASE + 32'(8 * i), data, 4'hf);
                end
            end
        join
        fork  // Fetch sampled on the edge after the write closes
            apb_write(BASE + 32'h40, 32'hcafe_0001, 4'hf);
            begin
                repeat (2) @(posedge clock);
                fetch_run(BASE + 32'h40, 1);
            end
        join

        apb_write(BASE - 32'd4, 32'hdead_beef, 4'hf);  // Illegal accesses
        apb_read(BASE - 32'd4);
        apb_write(TOP, 32'hdead_beef, 4'hf);
        apb_read(TOP);
        apb_read(TOP + 32'd8);
        apb_write(BASE + 32'd2, 32'hdead_beef, 4'hf);
        apb_read(BASE + 32'd5);
        apb_read(BASE);
        fetch_run(BASE - 32'd4, 1);
        fetch_run(TOP, 1);
        fetch_run(BASE + 32'd2, 1);

        for (int n = 0; n < 200; n++) begin  // Random mix
            next_rand(pick);
            next_rand(data);
            addr = pick_addr(pick);
            case (pick[27:26])
                2'd0, 2'd1: apb_write(addr, data, pick[23:20]);
                2'd2:       apb_read(addr);
                default:    fetch_run(addr, 2);
            endcase
        end

        repeat (3) @(posedge clock);
        $display("Closing count: %0d check errors, %0d timeouts", check_errors, timeout_count);
        if (check_errors == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/rv_bus_pkg.sv
rtl/rv_mem_pkg.sv
rtl/ram_mem.sv
rtl/apb_mem_bridge.sv
rtl/rv_mem_top.sv
bench/rv_mem_props.sv
bench/rv_mem_checker.sv
bench/rv_mem_tb.sv

// ==== include/rv_mem_defs.svh ====
`ifndef RV_MEM_DEFS_SVH
`define RV_MEM_DEFS_SVH

// Bus address of RAM byte 0
`define MEM_START_ADDRESS 32'h0001_0000

// RAM size in bytes, split over four byte lanes
`define MEM_SIZE_BYTES 4096

// Word index width for MEM_SIZE_BYTES / 4 words
`define MEM_INDEX_BITS 10

`endif

// ==== rtl/apb_mem_bridge.sv ====
`default_nettype none

`include "rv_mem_defs.svh"

module apb_mem_bridge
    import rv_bus_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      rst,
    input  wire apb_req_t  apb_req,  // Data port from load/store unit
    output apb_rsp_t       apb_rsp,
    output ram_wr_t        wr,       // Write command to RAM
    output ram_rd_t        rd,       // Read command to RAM
    input  wire mem_word_u rd_data   // Word read one cycle after rd.en
);

    logic        access;     // Access phase of a transfer
    logic [31:0] offset;     // Byte offset from RAM base
    logic        legal;      // Inside window and aligned
    word_index_t index;
    logic        wr_en;
    logic        rd_en;
    logic        rd_wait_q;  // RAM word arrives this cycle
    mem_word_u   wr_word;
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;

    assign access = apb_req.psel && apb_req.penable;
    assign offset = apb_req.paddr - `MEM_START_ADDRESS;  // Wraps high below base
    assign legal  = (offset < 32'(`MEM_SIZE_BYTES)) && (offset[1:0] == 2'b00);
    assign index  = offset[`MEM_INDEX_BITS+1:2];

    // Write lands on the closing edge
    assign wr_en = access && apb_req.pwrite && legal;

    // Read issued once in the first access cycle
    assign rd_en = access && !apb_req.pwrite && legal && !rd_wait_q;

    assign wr_word.word = apb_req.pwdata;  // Bus word into lane bytes

    assign wr = '{
        en:    wr_en,
        index: index,
        strb:  apb_req.pstrb,
        data:  wr_word
    };

    assign rd = '{
        en:    rd_en,
        index: index
    };

    // Wait flag lasts exactly one cycle since rd_en needs it low
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= rd_en;
        end
    end

    assign pready  = access && (!legal || apb_req.pwrite || rd_wait_q);  // Error ends at once
    assign pslverr = access && !legal;
    assign prdata  = (access && rd_wait_q) ? rd_data.word : 32'h0;      // Zero unless read data

    assign apb_rsp = '{
        pready:  pready,
        pslverr: pslverr,
        prdata:  prdata
    };

endmodule

`default_nettype wire

// ==== rtl/ram_mem.sv ====
`default_nettype none

`include "rv_mem_defs.svh"

module ram_mem
    import rv_mem_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst,
    input  wire fetch_req_t fetch_req,  // From fetch unit
    output fetch_rsp_t      fetch_rsp,  // One cycle after request
    input  wire ram_wr_t    wr,         // Strobed write from bridge
    input  wire ram_rd_t    rd,         // Data read from bridge
    output mem_word_u       rd_data     // Registered data word
);

    localparam int LANE_DEPTH = `MEM_SIZE_BYTES / 4;  // Words per lane

    logic [31:0] fetch_offset;   // Byte offset from RAM base
    logic        fetch_ok;       // Inside window and aligned
    word_index_t fetch_index;
    logic        fetch_valid_q;
    logic        fetch_fault_q;
    mem_word_u   fetch_word;     // Lane outputs joined

    // Below base wraps to a large offset and fails the size check
    assign fetch_offset = fetch_req.addr - `MEM_START_ADDRESS;
    assign fetch_ok     = (fetch_offset < 32'(`MEM_SIZE_BYTES))
                          && (fetch_offset[1:0] == 2'b00);
    assign fetch_index  = fetch_offset[`MEM_INDEX_BITS+1:2];  // Drop byte bits

    for (genvar l = 0; l < 4; l++) begin : g_lane
        logic [7:0] lane_mem [LANE_DEPTH] = '{default: 8'h00};  // Starts cleared
        logic [7:0] fetch_q;  // Fetch byte of this lane
        logic [7:0] rd_q;     // Data byte of this lane

        // Each lane written on its own strobe
        always_ff @(posedge clock) begin
            if (wr.en && wr.strb[l]) begin
                lane_mem[wr.index] <= wr.data.bytes[l];
            end
        end

        // Fetch read port
        always_ff @(posedge clock) begin
            if (fetch_req.valid) begin
                fetch_q <= fetch_ok ? lane_mem[fetch_index] : 8'h00;  // Zero on fault
            end
        end

        // Data read port
        always_ff @(posedge clock) begin
            if (rd.en) begin
                rd_q <= lane_mem[rd.index];
            end
        end
    end

    assign fetch_word.bytes = {
        g_lane[3].fetch_q,
        g_lane[2].fetch_q,
        g_lane[1].fetch_q,
        g_lane[0].fetch_q
    };

    assign rd_data.bytes = {
        g_lane[3].rd_q,
        g_lane[2].rd_q,
        g_lane[1].rd_q,
        g_lane[0].rd_q
    };

    always_ff @(posedge clock) begin
        if (rst) begin
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= fetch_req.valid;  // Answer follows request
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_req.valid) begin
            fetch_fault_q <= ~fetch_ok;  // Held with the word
        end
    end

    assign fetch_rsp = '{
        valid: fetch_valid_q,
        fault: fetch_fault_q,
        instr: fetch_word
    };

endmodule

`default_nettype wire

// ==== rtl/rv_bus_pkg.sv ====
`default_nettype none

package rv_bus_pkg;

    // Requester to slave signals of the data port
    typedef struct packed {
        logic        psel;     // Slave selected
        logic        penable;  // Access phase
        logic        pwrite;   // High for write
        logic [31:0] paddr;    // Byte address on the bus
        logic [31:0] pwdata;   // Write word
        logic [3:0]  pstrb;    // Byte lane strobes
    } apb_req_t;

    // Slave to requester signals of the data port
    typedef struct packed {
        logic        pready;   // Transfer closes this cycle
        logic        pslverr;  // Bad address or alignment
        logic [31:0] prdata;   // Read word, zero on error
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/rv_mem_pkg.sv ====
`default_nettype none

`include "rv_mem_defs.svh"

package rv_mem_pkg;

    typedef logic [`MEM_INDEX_BITS-1:0] word_index_t;  // Word slot within a lane

    // One RAM word seen whole or per byte lane
    typedef union packed {
        logic [31:0]     word;   // Bus side view
        logic [3:0][7:0] bytes;  // Lane view with byte 0 lowest
    } mem_word_u;

    typedef struct packed {
        logic        valid;  // Fetch wanted this cycle
        logic [31:0] addr;   // Instruction byte address
    } fetch_req_t;

    typedef struct packed {
        logic      valid;  // Answer to last cycle's request
        logic      fault;  // Address outside RAM or misaligned
        mem_word_u instr;  // Zero on fault
    } fetch_rsp_t;

    typedef struct packed {
        logic        en;     // Write this cycle
        word_index_t index;
        logic [3:0]  strb;   // Lanes to update
        mem_word_u   data;
    } ram_wr_t;

    typedef struct packed {
        logic        en;     // Read this cycle
        word_index_t index;
    } ram_rd_t;

endpackage

`default_nettype wire

// ==== rtl/rv_mem_top.sv ====
`default_nettype none

module rv_mem_top
    import rv_bus_pkg::*;
    import rv_mem_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst,
    input  wire apb_req_t   apb_req,    // Data port
    output apb_rsp_t        apb_rsp,
    input  wire fetch_req_t fetch_req,  // Instruction port
    output fetch_rsp_t      fetch_rsp
);

    ram_wr_t   ram_wr;       // Bridge write command
    ram_rd_t   ram_rd;       // Bridge read command
    mem_word_u ram_rd_data;  // Word back to bridge

    // Data port front end
    apb_mem_bridge u_bridge (
        .clock   (clock),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (ram_rd_data)
    );

    // Fetch goes straight to the RAM
    ram_mem u_ram (
        .clock     (clock),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .wr        (ram_wr),
        .rd        (ram_rd),
        .rd_data   (ram_rd_data)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_mem_tb -f flist.f || exit 1

out="$(./obj_dir/Vrv_mem_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
